/* common/dec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dec_if;

    // one decoded instruction, valid for a single cycle
    logic                          valid;
    rv_pkg::alu_op_t               op;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    // sign extended i-type or shifted u-type immediate
    logic [rv_pkg::xlen-1:0]       imm;
    // second operand comes from imm, not rs2
    logic                          use_imm;

    // decoder side
    modport source (
        output valid, op, rd, rs1, rs2, imm, use_imm
    );

    // execute side
    modport sink (
        input valid, op, rd, rs1, rs2, imm, use_imm
    );

endinterface

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data word width
    localparam int xlen = 32;

    // register index width, enough for x0..x31
    localparam int reg_addr_w = 5;

    // major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // alu operations after decode
    // register and immediate forms share one code
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_lui
    } alu_op_t;

endpackage

`default_nettype wire

/* compile.f */
common/rv_pkg.sv
common/dec_if.sv
decode/instr_decoder.sv
regfile/reg_file.sv
execute/alu_exec.sv
design/int_core_top.sv
test/core_tb.sv

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
    parameter int NUM_REGS = 32
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    output logic             illegal,
    dec_if.source            dec
);

    // instruction fields
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::reg_addr_w-1:0] rd_f;
    logic [rv_pkg::reg_addr_w-1:0] rs1_f;
    logic [rv_pkg::reg_addr_w-1:0] rs2_f;

    // decode results before the register stage
    rv_pkg::alu_op_t         op_n;
    logic [rv_pkg::xlen-1:0] imm_n;
    logic                    use_imm_n;
    logic                    enc_ok;
    logic                    rs1_used;
    logic                    rs2_used;
    logic                    reg_ok;
    logic                    legal;

    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        op_n      = rv_pkg::op_add;
        imm_n     = {{20{instr[31]}}, instr[31:20]};
        use_imm_n = 1'b0;
        enc_ok    = 1'b0;
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        case (opcode)
            rv_pkg::opc_op: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                // only funct7 0x00, plus 0x20 for sub and sra
                if (funct7 == 7'b0000000) begin
                    enc_ok = 1'b1;
                    case (funct3)
                        3'b000:  op_n = rv_pkg::op_add;
                        3'b001:  op_n = rv_pkg::op_sll;
                        3'b010:  op_n = rv_pkg::op_slt;
                        3'b011:  op_n = rv_pkg::op_sltu;
                        3'b100:  op_n = rv_pkg::op_xor;
                        3'b101:  op_n = rv_pkg::op_srl;
                        3'b110:  op_n = rv_pkg::op_or;
                        default: op_n = rv_pkg::op_and;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) begin
                        op_n   = rv_pkg::op_sub;
                        enc_ok = 1'b1;
                    end else if (funct3 == 3'b101) begin
                        op_n   = rv_pkg::op_sra;
                        enc_ok = 1'b1;
                    end
                end
            end
            rv_pkg::opc_op_imm: begin
                rs1_used  = 1'b1;
                use_imm_n = 1'b1;
                enc_ok    = 1'b1;
                case (funct3)
                    3'b000: op_n = rv_pkg::op_add;
                    3'b010: op_n = rv_pkg::op_slt;
                    3'b011: op_n = rv_pkg::op_sltu;
                    3'b100: op_n = rv_pkg::op_xor;
                    3'b110: op_n = rv_pkg::op_or;
                    3'b111: op_n = rv_pkg::op_and;
                    3'b001: begin
                        // slli, upper bits must be zero
                        op_n   = rv_pkg::op_sll;
                        enc_ok = (funct7 == 7'b0000000);
                    end
                    default: begin
                        // srli or srai picked by funct7
                        if (funct7 == 7'b0000000) begin
                            op_n = rv_pkg::op_srl;
                        end else begin
                            op_n   = rv_pkg::op_sra;
                            enc_ok = (funct7 == 7'b0100000);
                        end
                    end
                endcase
            end
            rv_pkg::opc_lui: begin
                op_n      = rv_pkg::op_lui;
                imm_n     = {instr[31:12], 12'b0};
                use_imm_n = 1'b1;
                enc_ok    = 1'b1;
            end
            default: begin
                enc_ok = 1'b0;
            end
        endcase
    end

    // indices past the implemented registers are illegal
    assign reg_ok = (int'(rd_f) < NUM_REGS)
                 && (!rs1_used || int'(rs1_f) < NUM_REGS)
                 && (!rs2_used || int'(rs2_f) < NUM_REGS);
    assign legal  = enc_ok && reg_ok;

    // strobes, one of the two per accepted instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec.valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec.valid <= instr_valid && legal;
            illegal   <= instr_valid && !legal;
        end
    end

    // payload, only meaningful while dec.valid is high
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.op      <= op_n;
            dec.rd      <= rd_f;
            dec.rs1     <= rs1_f;
            dec.rs2     <= rs2_f;
            dec.imm     <= imm_n;
            dec.use_imm <= use_imm_n;
        end
    end

endmodule

`default_nettype wire

/* design/int_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module int_core_top #(
    parameter int NUM_REGS = 32
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          instr_valid,
    input  wire logic [31:0]                   instr,
    output logic                               wb_valid,
    output logic      [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic      [rv_pkg::xlen-1:0]       wb_data,
    output logic                               illegal
);

    // decoded instruction, decoder to execute
    dec_if dec_bus ();

    // operand read path
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_pkg::xlen-1:0]       rs1_val;
    logic [rv_pkg::xlen-1:0]       rs2_val;

    // sample and decode, one edge
    instr_decoder #(
        .NUM_REGS (NUM_REGS)
    ) decoder_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .illegal     (illegal),
        .dec         (dec_bus.source)
    );

    // register array, writes land one edge after wb_valid rises
    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .we      (wb_valid),
        .rd      (wb_rd),
        .wd      (wb_data),
        .rs1     (rs1_addr),
        .rs2     (rs2_addr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    // execute, second edge
    alu_exec exec_i (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec_bus.sink),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

/* execute/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire logic                          clk,
    input  wire logic                          reset,
    dec_if.sink                                dec,
    output logic      [rv_pkg::reg_addr_w-1:0] rs1,
    output logic      [rv_pkg::reg_addr_w-1:0] rs2,
    input  wire logic [rv_pkg::xlen-1:0]       rs1_val,
    input  wire logic [rv_pkg::xlen-1:0]       rs2_val,
    output logic                               wb_valid,
    output logic      [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic      [rv_pkg::xlen-1:0]       wb_data
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic [rv_pkg::xlen-1:0] result;

    // read addresses straight from the decoded fields
    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    assign op_a = rs1_val;
    // immediate forms replace rs2
    assign op_b = dec.use_imm ? dec.imm : rs2_val;
    // shifts only look at the low five bits
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.op)
            rv_pkg::op_add: begin
                result = op_a + op_b;
            end
            rv_pkg::op_sub: begin
                result = op_a - op_b;
            end
            rv_pkg::op_sll: begin
                result = op_a << shamt;
            end
            rv_pkg::op_slt: begin
                // signed compare
                result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::op_sltu: begin
                result = {31'b0, op_a < op_b};
            end
            rv_pkg::op_xor: begin
                result = op_a ^ op_b;
            end
            rv_pkg::op_srl: begin
                result = op_a >> shamt;
            end
            rv_pkg::op_sra: begin
                // sign bit fills from the left
                result = $unsigned($signed(op_a) >>> shamt);
            end
            rv_pkg::op_or: begin
                result = op_a | op_b;
            end
            rv_pkg::op_and: begin
                result = op_a & op_b;
            end
            rv_pkg::op_lui: begin
                // upper immediate already shifted by the decoder
                result = dec.imm;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // writeback strobe, one cycle per decoded instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= dec.valid;
        end
    end

    // writeback payload
    // rd of zero still goes out, reg_file drops it
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            wb_rd   <= dec.rd;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

/* regfile/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          we,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd,
    input  wire logic [rv_pkg::xlen-1:0]       wd,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic      [rv_pkg::xlen-1:0]       rs1_val,
    output logic      [rv_pkg::xlen-1:0]       rs2_val
);

    // index bits actually needed for the array depth
    localparam int idx_w = $clog2(NUM_REGS);

    logic [rv_pkg::xlen-1:0] regs [NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd[idx_w-1:0]] <= wd;
        end
    end

    // combinational reads
    // x0 reads zero, a pending write to the same index is forwarded
    assign rs1_val = (rs1 == '0)           ? '0 :
                     (we && rd == rs1)     ? wd :
                                             regs[rs1[idx_w-1:0]];

    assign rs2_val = (rs2 == '0)           ? '0 :
                     (we && rd == rs2)     ? wd :
                                             regs[rs2[idx_w-1:0]];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f compile.f -o core_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/core_sim > sim.log 2>&1
cat sim.log

grep -qx "All checks passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* test/core_cases.txt */
// instr b2b kind rd data, b2b 1 means no idle cycles before the row
// kind 1 writeback with rd and data, kind 0 illegal with rd and data unused
123F0F13 0 1 1E 00000123 // addi x30, x30, 0x123
FFFF8F93 0 1 1F FFFFFFFF // addi x31, x31, -1
00500093 0 1 01 00000005 // addi x1, x0, 5
FFD00113 0 1 02 FFFFFFFD // addi x2, x0, -3
7FF00193 0 1 03 000007FF // addi x3, x0, 0x7ff
00208233 0 1 04 00000002 // add x4, x1, x2
402082B3 0 1 05 00000008 // sub x5, x1, x2
00409333 0 1 06 00000014 // sll x6, x1, x4
001123B3 0 1 07 00000001 // slt x7, x2, x1
00113433 0 1 08 00000000 // sltu x8, x2, x1
0020C4B3 0 1 09 FFFFFFF8 // xor x9, x1, x2
00415533 0 1 0A 3FFFFFFF // srl x10, x2, x4
404155B3 0 1 0B FFFFFFFF // sra x11, x2, x4
0030E633 0 1 0C 000007FF // or x12, x1, x3
003176B3 0 1 0D 000007FD // and x13, x2, x3
FFF12713 0 1 0E 00000001 // slti x14, x2, -1
FFF0B793 0 1 0F 00000001 // sltiu x15, x1, -1
FFF0C813 0 1 10 FFFFFFFA // xori x16, x1, -1
0F00E893 0 1 11 000000F5 // ori x17, x1, 0xf0
0FF17913 0 1 12 000000FD // andi x18, x2, 0xff
00409993 0 1 13 00000050 // slli x19, x1, 4
01C15A13 0 1 14 0000000F // srli x20, x2, 28
40115A93 0 1 15 FFFFFFFE // srai x21, x2, 1
12345B37 0 1 16 12345000 // lui x22, 0x12345
00708013 0 1 00 0000000C // addi x0, x1, 7
00100BB3 1 1 17 00000005 // add x23, x0, x1
001B0C13 0 1 18 12345001 // addi x24, x22, 1
001C0C13 1 1 18 12345002 // addi x24, x24, 1
018C0CB3 1 1 19 2468A004 // add x25, x24, x24
418C8D33 1 1 1A 12345002 // sub x26, x25, x24
FFFFFFFF 0 0 00 00000000 // unknown opcode
021080B3 0 0 00 00000000 // mul x1, x1, x1
40109093 1 0 00 00000000 // slli with funct7 0x20
00002083 0 0 00 00000000 // lw x1, 0(x0)
00008D93 1 1 1B 00000005 // addi x27, x1, 0
00520E33 0 1 1C 0000000A // add x28, x4, x5
0020BEB3 0 1 1D 00000001 // sltu x29, x1, x2

/* test/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int num_cases   = 37;
    // each row holds instr, b2b flag, kind, rd and data
    localparam int row_w       = 5;
    localparam int drain_limit = 20;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] case_mem [num_cases*row_w];
    int          edge_cnt = 0;
    int          err_cnt = 0;
    int          cases_done = 0;
    int          bad_cnt = 0;
    bit          mon_en = 1'b0;
    bit          case_bad [num_cases];
    integer      seed;

    // pending events as due edge plus case index
    int wb_due[$];
    int wb_case[$];
    int il_due[$];
    int il_case[$];

    int_core_top #(
        .NUM_REGS (32)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic mark_failed(input int idx);
        err_cnt++;
        case_bad[idx] = 1'b1;
    endtask

    task automatic print_case_result(input int idx);
        cases_done++;
        if (case_bad[idx]) begin
            bad_cnt++;
            $display("case %0d instr %h: mismatch", idx, case_mem[idx*row_w]);
        end else begin
            $display("case %0d instr %h: ok", idx, case_mem[idx*row_w]);
        end
    endtask

    task automatic check_writeback();
        int          idx;
        int          due;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        if (wb_due.size() != 0 && wb_due[0] == edge_cnt) begin
            due      = wb_due.pop_front();
            idx      = wb_case.pop_front();
            exp_rd   = case_mem[idx*row_w+3][4:0];
            exp_data = case_mem[idx*row_w+4];
            assert (wb_valid === 1'b1) else begin
                $display("case %0d: no writeback pulse at edge %0d", idx, due);
                mark_failed(idx);
            end
            if (wb_valid === 1'b1) begin
                assert (wb_rd === exp_rd) else begin
                    $display("CHECK FAILED wb_rd got %h expected %h", wb_rd, exp_rd);
                    mark_failed(idx);
                end
                assert (wb_data === exp_data) else begin
                    $display("CHECK FAILED wb_data got %h expected %h", wb_data, exp_data);
                    mark_failed(idx);
                end
            end
            print_case_result(idx);
        end else begin
            assert (wb_valid !== 1'b1) else begin
                $display("writeback pulse at edge %0d with none expected", edge_cnt);
                err_cnt++;
            end
        end
    endtask

    task automatic check_illegal();
        int idx;
        int due;
        if (il_due.size() != 0 && il_due[0] == edge_cnt) begin
            due = il_due.pop_front();
            idx = il_case.pop_front();
            assert (illegal === 1'b1) else begin
                $display("case %0d: illegal not raised at edge %0d", idx, due);
                mark_failed(idx);
            end
            print_case_result(idx);
        end else begin
            assert (illegal !== 1'b1) else begin
                $display("illegal pulse at edge %0d with none expected", edge_cnt);
                err_cnt++;
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (mon_en) begin
            check_writeback();
            check_illegal();
        end
    end

    initial begin
        int gap;
        int tmo;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 94;
        $readmemh("test/core_cases.txt", case_mem);
        assert (case_mem[0] !== 32'h0 && !$isunknown(case_mem[0])) else begin
            $display("case file test/core_cases.txt did not load");
            err_cnt++;
        end
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        reset  = 1'b0;
        mon_en = 1'b1;
        for (int i = 0; i < num_cases; i++) begin
            // draw every row so the sequence stays fixed
            gap = $unsigned($random(seed)) % 3;
            if (case_mem[i*row_w+1][0]) begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
                instr_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            instr_valid = 1'b1;
            instr       = case_mem[i*row_w];
            // sampled at edge_cnt + 1
            if (case_mem[i*row_w+2][0]) begin
                wb_due.push_back(edge_cnt + 2);
                wb_case.push_back(i);
            end else begin
                il_due.push_back(edge_cnt + 1);
                il_case.push_back(i);
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        tmo = 0;
        while ((wb_due.size() != 0 || il_due.size() != 0) && tmo < drain_limit) begin
            @(posedge clk);
            tmo++;
        end
        assert (wb_due.size() == 0 && il_due.size() == 0) else begin
            $display("timed out with %0d expected pulses missing", wb_due.size() + il_due.size());
            err_cnt++;
        end
        // quiet cycles catch stray pulses
        repeat (3) begin
            @(posedge clk);
        end
        $display("cases checked %0d, cases bad %0d, errors %0d", cases_done, bad_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
